// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := unpack_tb
FILELIST := bit_unpack.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bit_unpack.f
source/unpack_pkg.sv
source/word_fifo.sv
source/bit_fifo.sv
source/unpack_ctrl.sv
source/unpack_top.sv
verification/unpack_tb.sv

// File: source/bit_fifo.sv
// ==============================
// bit_fifo: two-word bit FIFO with
// variable-width push and pop, LSB first
// ==============================

`default_nettype none

module bit_fifo (
  input  wire                             clk_i,
  input  wire                             rst_n_i,

  // push side
  input  wire                             write_i,
  input  wire [unpack_pkg::WIDTH_W-1:0]   wwidth_i,
  input  wire [unpack_pkg::DATA_W-1:0]    wdata_i,
  output logic [unpack_pkg::LEVEL_W-1:0]  wlevel_o,

  // pop side
  input  wire                             read_i,
  input  wire [unpack_pkg::WIDTH_W-1:0]   rwidth_i,
  output logic [unpack_pkg::DATA_W-1:0]   rdata_o,
  output logic [unpack_pkg::LEVEL_W-1:0]  rlevel_o
);

  // bit storage, oldest bit at position 0
  logic [2*unpack_pkg::DATA_W-1:0] data_q;
  logic [2*unpack_pkg::DATA_W-1:0] data_d;
  logic [2*unpack_pkg::DATA_W-1:0] keep_mask;
  logic [2*unpack_pkg::DATA_W-1:0] wr_bits_ext;
  logic [unpack_pkg::DATA_W-1:0]   wr_bits;

  // fill count in bits
  logic [unpack_pkg::LEVEL_W-1:0]  level_q;
  logic [unpack_pkg::LEVEL_W-1:0]  level_pop;
  logic [unpack_pkg::LEVEL_W-1:0]  level_d;

  // effective bit counts this cycle
  logic [unpack_pkg::WIDTH_W-1:0]  rd_cnt;
  logic [unpack_pkg::WIDTH_W-1:0]  wr_cnt;

  assign rd_cnt = read_i ? rwidth_i : '0;
  assign wr_cnt = write_i ? wwidth_i : '0;

  // pop first, then append the new bits above what is left
  assign level_pop = level_q - unpack_pkg::LEVEL_W'(rd_cnt);
  assign level_d   = level_pop + unpack_pkg::LEVEL_W'(wr_cnt);

  // only bits below the remaining level survive the shift
  assign keep_mask = ~({(2*unpack_pkg::DATA_W){1'b1}} << level_pop);

  assign wr_bits     = wdata_i & ~({unpack_pkg::DATA_W{1'b1}} << wr_cnt);
  assign wr_bits_ext = {{unpack_pkg::DATA_W{1'b0}}, wr_bits};

  assign data_d = ((data_q >> rd_cnt) & keep_mask) | (wr_bits_ext << level_pop);

  // field at the bottom, zero-extended to a full word
  assign rdata_o = data_q[unpack_pkg::DATA_W-1:0]
                   & ~({unpack_pkg::DATA_W{1'b1}} << rwidth_i);

  assign rlevel_o = level_q;
  assign wlevel_o = unpack_pkg::LEVEL_W'(2 * unpack_pkg::DATA_W) - level_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      level_q <= '0;
    end else if (read_i || write_i) begin
      level_q <= level_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_i || write_i) begin
      data_q <= data_d;
    end
  end

  // the controller checks room before every push
  a_push_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    write_i |-> ({1'b0, wwidth_i} <= wlevel_o));

  // and stored bits before every pop
  a_pop_avail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_i |-> ({1'b0, rwidth_i} <= rlevel_o));

endmodule

`default_nettype wire

// File: source/unpack_ctrl.sv
// ==============================
// unpack_ctrl: four-step sequencer that
// feeds the bit FIFO and pops fields
// ==============================

`default_nettype none

module unpack_ctrl (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            wrap_i,
  input  wire [unpack_pkg::WIDTH_W-1:0]  width_i,

  // input word FIFO
  input  wire                            rready_i,
  output logic                           read_o,

  // output word FIFO
  input  wire                            wready_i,
  output logic                           write_o,

  // bit FIFO
  output logic                           push_o,
  output logic [unpack_pkg::WIDTH_W-1:0] push_width_o,
  input  wire [unpack_pkg::LEVEL_W-1:0]  push_level_i,
  input  wire [unpack_pkg::LEVEL_W-1:0]  pop_level_i
);

  unpack_pkg::ctrl_state_e        state_q;
  unpack_pkg::ctrl_state_e        state_d;

  // bits of whole fields per word in wrap mode
  logic [unpack_pkg::WIDTH_W-1:0] wrap_acc_q;
  logic [unpack_pkg::WIDTH_W-1:0] wrap_acc_d;
  logic [unpack_pkg::WIDTH_W:0]   wrap_sum;

  assign push_width_o = wrap_i ? wrap_acc_q : unpack_pkg::WIDTH_W'(unpack_pkg::DATA_W);
  assign wrap_sum     = {1'b0, wrap_acc_q} + {1'b0, width_i};

  always_comb begin
    state_d    = state_q;
    wrap_acc_d = wrap_acc_q;
    read_o     = 1'b0;
    push_o     = 1'b0;
    write_o    = 1'b0;

    case (state_q)
      unpack_pkg::CALC_PUSH_WIDTH: begin
        // keep adding fields while another one still fits
        if (wrap_i && (wrap_sum <= (unpack_pkg::WIDTH_W + 1)'(unpack_pkg::DATA_W))) begin
          wrap_acc_d = wrap_sum[unpack_pkg::WIDTH_W-1:0];
        end else begin
          state_d = unpack_pkg::WAIT_DATA;
        end
      end
      unpack_pkg::WAIT_DATA: begin
        // word waiting and room for a full push
        if (rready_i && (push_level_i >= {1'b0, push_width_o})) begin
          state_d = unpack_pkg::PUSH_DATA;
        end else begin
          state_d = unpack_pkg::POP_DATA;
        end
      end
      unpack_pkg::PUSH_DATA: begin
        // head word moves into the bit FIFO as it leaves the input FIFO
        push_o  = 1'b1;
        read_o  = 1'b1;
        state_d = unpack_pkg::POP_DATA;
      end
      default: begin
        if ((pop_level_i >= {1'b0, width_i}) && wready_i) begin
          write_o = 1'b1;
        end
        state_d = unpack_pkg::WAIT_DATA;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= unpack_pkg::CALC_PUSH_WIDTH;
      wrap_acc_q <= '0;
    end else begin
      state_q    <= state_d;
      wrap_acc_q <= wrap_acc_d;
    end
  end

  // field width legal and held for the whole run
  a_width_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (width_i >= 1) && (width_i <= unpack_pkg::WIDTH_W'(unpack_pkg::DATA_W)));

  a_config_static: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ##1 $stable(width_i) && $stable(wrap_i));

endmodule

`default_nettype wire

// File: source/unpack_pkg.sv
// ==============================
// unpack_pkg: shared widths, FIFO depths
// and controller states of the unpacker
// ==============================

`default_nettype none

package unpack_pkg;

  // packed and unpacked word width
  localparam int DATA_W = 32;

  // bit count 0..DATA_W
  localparam int WIDTH_W = 6;

  // bit FIFO level 0..2*DATA_W
  localparam int LEVEL_W = 7;

  // word FIFO depths
  localparam int IN_DEPTH = 4;
  localparam int OUT_DEPTH = 2;

  // controller sequence, one step per cycle
  typedef enum logic [1:0] {
    CALC_PUSH_WIDTH = 2'd0,
    WAIT_DATA       = 2'd1,
    PUSH_DATA       = 2'd2,
    POP_DATA        = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/unpack_top.sv
// ==============================
// unpack_top: bit-stream unpacker
// ==============================

`default_nettype none

module unpack_top (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire [unpack_pkg::WIDTH_W-1:0]  width_i,
  input  wire                            wrap_i,
  input  wire                            in_valid_i,
  output logic                           in_ready_o,
  input  wire [unpack_pkg::DATA_W-1:0]   in_data_i,
  output logic                           out_valid_o,
  input  wire                            out_ready_i,
  output logic [unpack_pkg::DATA_W-1:0]  out_data_o
);

  logic                           in_rd_valid;
  logic [unpack_pkg::DATA_W-1:0]  in_rd_data;
  logic                           read;
  logic                           push;
  logic [unpack_pkg::WIDTH_W-1:0] push_width;
  logic [unpack_pkg::LEVEL_W-1:0] push_level;
  logic [unpack_pkg::LEVEL_W-1:0] pop_level;
  logic                           pop;
  logic [unpack_pkg::DATA_W-1:0]  field;
  logic                           out_wr_ready;

  word_fifo #(.DEPTH(unpack_pkg::IN_DEPTH)) i_in_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_valid_i(in_valid_i),
    .wr_data_i (in_data_i),
    .wr_ready_o(in_ready_o),
    .rd_valid_o(in_rd_valid),
    .rd_ready_i(read),
    .rd_data_o (in_rd_data)
  );

  unpack_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wrap_i      (wrap_i),
    .width_i     (width_i),
    .rready_i    (in_rd_valid),
    .read_o      (read),
    .wready_i    (out_wr_ready),
    .write_o     (pop),
    .push_o      (push),
    .push_width_o(push_width),
    .push_level_i(push_level),
    .pop_level_i (pop_level)
  );

  bit_fifo i_bit_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .write_i (push),
    .wwidth_i(push_width),
    .wdata_i (in_rd_data),
    .wlevel_o(push_level),
    .read_i  (pop),
    .rwidth_i(width_i),
    .rdata_o (field),
    .rlevel_o(pop_level)
  );

  word_fifo #(.DEPTH(unpack_pkg::OUT_DEPTH)) i_out_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_valid_i(pop),
    .wr_data_i (field),
    .wr_ready_o(out_wr_ready),
    .rd_valid_o(out_valid_o),
    .rd_ready_i(out_ready_i),
    .rd_data_o (out_data_o)
  );

endmodule

`default_nettype wire

// File: source/word_fifo.sv
// ==============================
// word_fifo: synchronous word FIFO,
// valid/ready on both sides
// ==============================

`default_nettype none

module word_fifo #(
  parameter int DEPTH = 4
) (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            wr_valid_i,
  input  wire [unpack_pkg::DATA_W-1:0]   wr_data_i,
  output logic                           wr_ready_o,
  output logic                           rd_valid_o,
  input  wire                            rd_ready_i,
  output logic [unpack_pkg::DATA_W-1:0]  rd_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [unpack_pkg::DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]              wr_ptr_q;
  logic [PTR_W-1:0]              rd_ptr_q;
  logic [CNT_W-1:0]              count_q;
  logic                          do_push;
  logic                          do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // full FIFO still takes a word when the head leaves this cycle
  assign rd_valid_o = (count_q != '0);
  assign wr_ready_o = (count_q != CNT_W'(DEPTH)) || rd_ready_i;
  assign do_pop     = rd_valid_o && rd_ready_i;
  assign do_push    = wr_valid_i && wr_ready_o;
  assign rd_data_o  = mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= wr_data_i;
  end

  // occupancy stays in range, an underflow would wrap above DEPTH
  a_count_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CNT_W'(DEPTH));

  // a stalled head word holds until it is taken
  a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o));

endmodule

`default_nettype wire

// File: verification/unpack_tb.sv
// ==============================
// testbench for the unpacker with a
// reference queue and checking assertions
// ==============================

`default_nettype none

module unpack_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 3000;

  logic        clk_i = 1'b0;
  logic        rst_n_i = 1'b0;
  logic [5:0]  width_i = 6'd8;
  logic        wrap_i = 1'b0;
  logic        in_valid_i = 1'b0;
  logic        in_ready_o;
  logic [31:0] in_data_i = '0;
  logic        out_valid_o;
  logic        out_ready_i = 1'b1;
  logic [31:0] out_data_o;

  logic [31:0] exp_q[$];
  logic        bits_q[$];
  logic [31:0] exp_head = '0;
  logic        exp_empty = 1'b1;
  logic [31:0] field_mask;
  logic [15:0] word_lfsr = 16'd37;
  logic [15:0] ready_lfsr = 16'd37;
  logic        random_ready = 1'b0;
  logic        saw_full = 1'b0;
  string       test_name = "init";
  int          errors = 0;
  int          err_start = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  unpack_top i_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .width_i    (width_i),
    .wrap_i     (wrap_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_data_i  (in_data_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_data_o (out_data_o)
  );

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one bit set for each field bit below the configured width
  always_comb begin
    field_mask = '0;
    for (int b = 0; b < 32; b++) begin
      if (b < int'(width_i)) begin
        field_mask[b] = 1'b1;
      end
    end
  end

  always @(negedge clk_i) begin
    if (random_ready) begin
      ready_lfsr = lfsr_step(ready_lfsr);
      out_ready_i = ready_lfsr[0];
    end else begin
      out_ready_i = 1'b1;
    end
  end

  // reference model builds fields LSB first
  task automatic add_expected(input logic [31:0] word);
    logic [31:0] field;
    int          w;
    w = int'(width_i);
    if (wrap_i) begin
      for (int k = 0; k < 32 / w; k++) begin
        field = '0;
        for (int b = 0; b < w; b++) field[b] = word[k * w + b];
        exp_q.push_back(field);
      end
    end else begin
      for (int b = 0; b < 32; b++) bits_q.push_back(word[b]);
      while (bits_q.size() >= w) begin
        field = '0;
        for (int b = 0; b < w; b++) field[b] = bits_q.pop_front();
        exp_q.push_back(field);
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_q.delete();
      bits_q.delete();
    end else begin
      if (out_valid_o && out_ready_i && exp_q.size() > 0) void'(exp_q.pop_front());
      if (in_valid_i && in_ready_o) add_expected(in_data_i);
      if (!in_ready_o) saw_full = 1'b1;
    end
    exp_empty <= (exp_q.size() == 0);
    exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
  end

  a_reset_state: assert property (@(posedge clk_i)
    (!rst_n_i || $rose(rst_n_i)) |-> (!out_valid_o && in_ready_o))
    else begin
      $display("%s: output valid or input not ready around reset", test_name);
      errors++;
    end

  a_field_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i && !exp_empty |-> out_data_o == exp_head)
    else begin
      $display("[FAIL] %s expected %h actual %h", test_name, $sampled(exp_head),
               $sampled(out_data_o));
      errors++;
    end

  a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> !exp_empty)
    else begin
      $display("%s: output field arrived when none was expected", test_name);
      errors++;
    end

  a_upper_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> (out_data_o & ~field_mask) == '0)
    else begin
      $display("[FAIL] %s expected %h actual %h", test_name, 32'h0,
               $sampled(out_data_o & ~field_mask));
      errors++;
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else begin
      $display("%s: output word changed while stalled", test_name);
      errors++;
    end

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
    saw_full  = 1'b0;
  endtask

  task automatic end_test();
    int n;
    n = errors - err_start;
    if (n == 0) begin
      pass_cnt++;
      $display("test %s: passed", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", test_name, n);
    end
  endtask

  // new configuration only while reset is held
  task automatic run_reset(input int w, input logic wrap);
    @(negedge clk_i);
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    width_i    = 6'(w);
    wrap_i     = wrap;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
  endtask

  task automatic send_word(input logic [31:0] data);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    in_valid_i = 1'b1;
    in_data_i  = data;
    while (!taken && waited < TIMEOUT) begin
      taken = in_ready_o;
      @(negedge clk_i);
      waited++;
    end
    in_valid_i = 1'b0;
    if (!taken) begin
      $display("%s: input word was never accepted", test_name);
      errors++;
    end
  endtask

  task automatic send_burst(input int n);
    logic [31:0] word;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < 32; b++) begin
        word_lfsr = lfsr_step(word_lfsr);
        word[b]   = word_lfsr[0];
      end
      send_word(word);
    end
  endtask

  // all expected fields out, then a quiet spell for extras
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("%s: %0d fields still missing after timeout", test_name, exp_q.size());
      errors++;
    end
    repeat (40) @(negedge clk_i);
  endtask

  initial begin
    begin_test("reset_state");
    run_reset(8, 1'b0);
    repeat (5) @(negedge clk_i);
    end_test();

    begin_test("continuous_w8");
    send_burst(12);
    drain();
    end_test();

    begin_test("continuous_w5");
    run_reset(5, 1'b0);
    send_burst(10);
    drain();
    end_test();

    begin_test("wrap_w7");
    run_reset(7, 1'b1);
    send_burst(8);
    drain();
    end_test();

    begin_test("wrap_w32");
    run_reset(32, 1'b1);
    send_burst(6);
    drain();
    end_test();

    begin_test("back_pressure");
    run_reset(3, 1'b0);
    random_ready = 1'b1;
    send_burst(40);
    drain();
    random_ready = 1'b0;
    if (!saw_full) begin
      $display("%s: input ready never fell under back-pressure", test_name);
      errors++;
    end
    end_test();

    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
